//--- rtl/eth_tx_pkg.sv
package eth_tx_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stream and queue sizing
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int data_w      = 8;        // Byte stream width
    localparam int queue_depth = 64;       // Entries per frame queue
    localparam int queue_aw    = 6;        // Pointer width, depth is 2**queue_aw

    // Counts whole frames held in one queue; a queue full of
    // one-byte frames needs room for queue_depth
    localparam int frame_cnt_w = 7;

    // ~~~~~~~~~~~~~~~~~~~~
    // Line timing
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int ifg_cycles = 3;                        // Idle cycles between frames
    localparam int gap_w      = $clog2(ifg_cycles + 1);   // Gap counter width

    // ~~~~~~~~~~~~~~~~~~~~
    // Arbiter state codes
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int state_w = 2;

    localparam logic [state_w-1:0] st_idle  = 2'b00;   // Line free
    localparam logic [state_w-1:0] st_port0 = 2'b01;   // Port 0 owns the line
    localparam logic [state_w-1:0] st_port1 = 2'b10;   // Port 1 owns the line

endpackage

//--- rtl/eth_arbiter.sv
`timescale 1ns/100ps

module eth_arbiter (
    input  logic clk,
    input  logic rstn,
    input  logic req0,
    input  logic req1,
    input  logic done0,
    input  logic done1,
    output logic sel0,
    output logic sel1
);

    import eth_tx_pkg::*;

    logic [state_w-1:0] state;
    logic [state_w-1:0] next_state;

    // ~~~~~~~~~~~~~~~~~~~~
    // State register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Grant is held for a whole frame, released only by that port's done
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req0) begin
                    next_state = st_port0;   // Port 0 wins a tie
                end else if (req1) begin
                    next_state = st_port1;
                end
            end
            st_port0: begin
                if (done0) begin
                    next_state = st_idle;
                end
            end
            st_port1: begin
                if (done1) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;        // Unused code
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Select outputs
    // ~~~~~~~~~~~~~~~~~~~~

    assign sel0 = (state == st_port0);   // Decoded from the register
    assign sel1 = (state == st_port1);

    // Only one frame owns the line at a time
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        !(sel0 && sel1)
    );

    // The multiplexer may only finish a frame it was granted
    a_done0_granted: assert property (
        @(posedge clk) disable iff (!rstn)
        done0 |-> sel0
    );

    a_done1_granted: assert property (
        @(posedge clk) disable iff (!rstn)
        done1 |-> sel1
    );

endmodule

//--- rtl/frame_queue.sv
`timescale 1ns/100ps

module frame_queue (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [eth_tx_pkg::data_w-1:0] in_data,
    input  logic                       in_last,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [eth_tx_pkg::data_w-1:0] q_data,
    output logic                       q_last,
    output logic                       q_valid,
    input  logic                       q_ready,
    output logic                       req
);

    import eth_tx_pkg::*;

    localparam logic [queue_aw:0] full_count = (queue_aw + 1)'(queue_depth);

    logic [data_w-1:0]      data_mem [queue_depth];   // Payload bytes
    logic                   last_mem [queue_depth];   // End-of-frame marks
    logic [queue_aw-1:0]    wr_ptr;
    logic [queue_aw-1:0]    rd_ptr;
    logic [queue_aw:0]      count;                    // Bytes stored
    logic [frame_cnt_w-1:0] frame_cnt;                // Complete frames stored
    logic                   wr_en;
    logic                   rd_en;
    logic                   frame_in;
    logic                   frame_out;

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshakes
    // ~~~~~~~~~~~~~~~~~~~~

    assign in_ready  = (count != full_count);   // Low only when full
    assign q_valid   = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = q_valid && q_ready;
    assign frame_in  = wr_en && in_last;
    assign frame_out = rd_en && q_last;

    // Head entry read straight from the array
    assign q_data = data_mem[rd_ptr];
    assign q_last = last_mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame counter
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_cnt <= '0;
        end else begin
            case ({frame_in, frame_out})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    assign req = (frame_cnt != '0);   // Ask only with a whole frame inside

    // A write never lands on the unread head entry
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rstn)
        (wr_en && (count != '0)) |-> (wr_ptr != rd_ptr)
    );

    // A read never takes an entry that was not written
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rstn)
        rd_en |-> ((wr_ptr != rd_ptr) || (count == full_count))
    );

endmodule

//--- rtl/tx_stream_mux.sv
`timescale 1ns/100ps

module tx_stream_mux (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          sel0,
    input  logic                          sel1,
    input  logic [eth_tx_pkg::data_w-1:0] q_data0,
    input  logic [eth_tx_pkg::data_w-1:0] q_data1,
    input  logic                          q_last0,
    input  logic                          q_last1,
    input  logic                          q_valid0,
    input  logic                          q_valid1,
    output logic                          q_ready0,
    output logic                          q_ready1,
    output logic                          done0,
    output logic                          done1,
    output logic [eth_tx_pkg::data_w-1:0] out_data,
    output logic                          out_last,
    output logic                          out_valid,
    output logic                          out_port,
    input  logic                          out_ready
);

    import eth_tx_pkg::*;

    logic [gap_w-1:0] gap_cnt;      // Idle cycles still owed
    logic             gap_clear;
    logic             xfer;
    logic             xfer_last;
    logic             in_frame;     // Between first and last byte
    logic             frame_port;   // Owner of the frame in flight

    assign gap_clear = (gap_cnt == '0);

    // ~~~~~~~~~~~~~~~~~~~~
    // Steering
    // ~~~~~~~~~~~~~~~~~~~~

    assign out_port  = sel1;                          // Stable while a grant lasts
    assign out_data  = sel1 ? q_data1 : q_data0;
    assign out_last  = sel1 ? q_last1 : q_last0;
    assign out_valid = gap_clear && ((sel0 && q_valid0) || (sel1 && q_valid1));

    // Back-pressure goes only to the queue that owns the line
    assign q_ready0 = sel0 && gap_clear && out_ready;
    assign q_ready1 = sel1 && gap_clear && out_ready;

    assign xfer      = out_valid && out_ready;
    assign xfer_last = xfer && out_last;

    assign done0 = xfer_last && sel0;   // One cycle, on the last byte
    assign done1 = xfer_last && sel1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Inter-frame gap
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gap_cnt <= '0;
        end else if (xfer_last) begin
            gap_cnt <= gap_w'(ifg_cycles);   // Starts at the last-byte edge
        end else if (!gap_clear) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

    // Track the frame in flight for the ownership check
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_frame   <= 1'b0;
            frame_port <= 1'b0;
        end else if (xfer) begin
            in_frame   <= !out_last;
            frame_port <= out_port;
        end
    end

    // A frame never changes owner part way through
    a_port_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (in_frame && out_valid) |-> (out_port == frame_port)
    );

endmodule

//--- rtl/eth_tx_mux_top.sv
`timescale 1ns/100ps

module eth_tx_mux_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [eth_tx_pkg::data_w-1:0] in_data0,
    input  logic [eth_tx_pkg::data_w-1:0] in_data1,
    input  logic                          in_last0,
    input  logic                          in_last1,
    input  logic                          in_valid0,
    input  logic                          in_valid1,
    output logic                          in_ready0,
    output logic                          in_ready1,
    output logic [eth_tx_pkg::data_w-1:0] out_data,
    output logic                          out_last,
    output logic                          out_valid,
    output logic                          out_port,
    input  logic                          out_ready
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Internal wiring
    // ~~~~~~~~~~~~~~~~~~~~

    logic [eth_tx_pkg::data_w-1:0] q_data0;
    logic [eth_tx_pkg::data_w-1:0] q_data1;
    logic                          q_last0;
    logic                          q_last1;
    logic                          q_valid0;
    logic                          q_valid1;
    logic                          q_ready0;
    logic                          q_ready1;
    logic                          req0;
    logic                          req1;
    logic                          sel0;
    logic                          sel1;
    logic                          done0;
    logic                          done1;

    frame_queue u_queue0 (
        .clk      (clk),
        .rstn     (rstn),
        .in_data  (in_data0),
        .in_last  (in_last0),
        .in_valid (in_valid0),
        .in_ready (in_ready0),
        .q_data   (q_data0),
        .q_last   (q_last0),
        .q_valid  (q_valid0),
        .q_ready  (q_ready0),
        .req      (req0)
    );

    frame_queue u_queue1 (
        .clk      (clk),
        .rstn     (rstn),
        .in_data  (in_data1),
        .in_last  (in_last1),
        .in_valid (in_valid1),
        .in_ready (in_ready1),
        .q_data   (q_data1),
        .q_last   (q_last1),
        .q_valid  (q_valid1),
        .q_ready  (q_ready1),
        .req      (req1)
    );

    eth_arbiter u_arbiter (
        .clk   (clk),
        .rstn  (rstn),
        .req0  (req0),
        .req1  (req1),
        .done0 (done0),
        .done1 (done1),
        .sel0  (sel0),
        .sel1  (sel1)
    );

    tx_stream_mux u_mux (
        .clk       (clk),
        .rstn      (rstn),
        .sel0      (sel0),
        .sel1      (sel1),
        .q_data0   (q_data0),
        .q_data1   (q_data1),
        .q_last0   (q_last0),
        .q_last1   (q_last1),
        .q_valid0  (q_valid0),
        .q_valid1  (q_valid1),
        .q_ready0  (q_ready0),
        .q_ready1  (q_ready1),
        .done0     (done0),
        .done1     (done1),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_port  (out_port),
        .out_ready (out_ready)
    );

endmodule

//--- bench/tx_checker.sv
`timescale 1ns/100ps

module tx_checker (
    input logic                          clk,
    input logic                          rstn,
    input logic                          in_valid0,
    input logic                          in_valid1,
    input logic                          in_ready0,
    input logic                          in_ready1,
    input logic [eth_tx_pkg::data_w-1:0] out_data,
    input logic                          out_last,
    input logic                          out_valid,
    input logic                          out_port,
    input logic                          out_ready
);

    import eth_tx_pkg::*;

    logic [data_w:0] exp_q0 [$];                  // {last, data} still owed by port 0
    logic [data_w:0] exp_q1 [$];
    logic [data_w:0] exp;
    int              data_errs  = 0;
    int              frame_errs = 0;
    int              gap_errs   = 0;
    int              order_errs = 0;
    int              flow_errs  = 0;
    int              occ0       = 0;              // Bytes held in queue 0
    int              occ1       = 0;
    int              idle_cnt   = ifg_cycles;     // No gap owed before the first frame
    logic            in_frame   = 1'b0;
    logic            frame_port = 1'b0;
    logic            want_port0 = 1'b0;           // Armed before a tied start
    logic            saw_full   = 1'b0;

    task automatic expect_byte(input logic port, input logic [data_w-1:0] data,
                               input logic last);
        if (port) begin
            exp_q1.push_back({last, data});
        end else begin
            exp_q0.push_back({last, data});
        end
    endtask

    task automatic arm_order_check();
        want_port0 = 1'b1;
    endtask

    function automatic logic all_consumed();
        return (exp_q0.size() == 0) && (exp_q1.size() == 0);
    endfunction

    task automatic check_queue_filled();
        if (!saw_full) begin
            $display("No input queue ever filled up, in_ready never dropped");
            flow_errs++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~

    // Outputs are settled at the falling edge, the transfer happens at the next rise
    always @(negedge clk) begin
        // A queue refuses bytes only once it holds queue_depth of them
        if (in_ready0 !== (occ0 != queue_depth)) begin
            $display("Fail at %0t: in_ready0 expected %b got %b",
                     $time, occ0 != queue_depth, in_ready0);
            flow_errs++;
        end
        if (in_ready1 !== (occ1 != queue_depth)) begin
            $display("Fail at %0t: in_ready1 expected %b got %b",
                     $time, occ1 != queue_depth, in_ready1);
            flow_errs++;
        end
        if (!in_ready0 || !in_ready1) begin
            saw_full = 1'b1;
        end
        if (in_valid0 && in_ready0) begin
            occ0++;                                           // Written at the next rise
        end
        if (in_valid1 && in_ready1) begin
            occ1++;
        end
        if (!rstn) begin
            if (out_valid) begin
                $display("At %0t out_valid was high during reset", $time);
                frame_errs++;
            end
        end else begin
            if (out_valid && !in_frame) begin                 // Start of a frame
                if (idle_cnt < ifg_cycles) begin
                    $display("Fail at %0t: idle gap expected >= %0d got %0d",
                             $time, ifg_cycles, idle_cnt);
                    gap_errs++;
                end
                if (want_port0 && out_port) begin
                    $display("Fail at %0t: out_port expected 0 got 1", $time);
                    order_errs++;
                end
                want_port0 = 1'b0;
                in_frame   = 1'b1;
                frame_port = out_port;
            end else if (out_valid && (out_port !== frame_port)) begin
                $display("Fail at %0t: out_port expected %0d got %0d", $time, frame_port, out_port);
                frame_errs++;
            end
            if (out_valid && out_ready) begin
                if (out_port) begin
                    occ1--;
                end else begin
                    occ0--;
                end
                if ((out_port ? exp_q1.size() : exp_q0.size()) == 0) begin
                    $display("At %0t a byte came out on port %0d with no frame pending",
                             $time, out_port);
                    frame_errs++;
                end else begin
                    if (out_port) begin
                        exp = exp_q1.pop_front();
                    end else begin
                        exp = exp_q0.pop_front();
                    end
                    if (out_data !== exp[data_w-1:0]) begin
                        $display("Fail at %0t: out_data expected %h got %h",
                                 $time, exp[data_w-1:0], out_data);
                        data_errs++;
                    end
                    if (out_last !== exp[data_w]) begin
                        $display("Fail at %0t: out_last expected %b got %b",
                                 $time, exp[data_w], out_last);
                        data_errs++;
                    end
                end
                if (out_last) begin
                    in_frame = 1'b0;
                    idle_cnt = 0;                             // Gap counts from here
                end
            end else if (!out_valid) begin
                idle_cnt++;
            end
        end
    end

endmodule

//--- bench/tb_eth_tx_mux.sv
`timescale 1ns/100ps

module tb_eth_tx_mux;

    import eth_tx_pkg::*;

    localparam int n_rows        = 12;
    localparam int clk_period    = 40;
    localparam int byte_timeout  = 500;     // Cycles to wait for in_ready
    localparam int drain_timeout = 2000;    // Cycles to wait for the output to empty

    logic                   clk;
    logic                   rstn;
    logic [1:0][data_w-1:0] in_data;
    logic [1:0]             in_last;
    logic [1:0]             in_valid;
    logic [1:0]             in_ready;
    logic [data_w-1:0]      out_data;
    logic                   out_last;
    logic                   out_valid;
    logic                   out_port;
    logic                   out_ready;
    logic [31:0]            rng;
    time                    stall_end;
    int                     timeouts;
    int                     errors;
    logic                   timed_out;

    // Columns: port, length, first byte, start together with next row, output stall cycles
    int frame_table [n_rows][5] = '{
        '{0,  5, 'h10, 0,   0},
        '{1,  3, 'h40, 0,   0},
        '{0,  1, 'hA0, 0,   0},            // Single-byte frame
        '{0,  4, 'h20, 1,   0},            // Tied start, port 0 listed first
        '{1,  4, 'h70, 0,   0},
        '{1,  6, 'hC0, 1,   0},            // Tied start, port 1 listed first
        '{0,  6, 'h30, 0,   0},
        '{1, 30, 'h80, 0, 120},            // Three frames overfill queue 1
        '{1, 30, 'h9E, 0,   0},
        '{1, 30, 'hBC, 0,   0},
        '{0, 12, 'hE0, 0,   0},
        '{1,  2, 'hF0, 0,   0}
    };

    eth_tx_mux_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_data0  (in_data[0]),
        .in_data1  (in_data[1]),
        .in_last0  (in_last[0]),
        .in_last1  (in_last[1]),
        .in_valid0 (in_valid[0]),
        .in_valid1 (in_valid[1]),
        .in_ready0 (in_ready[0]),
        .in_ready1 (in_ready[1]),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_port  (out_port),
        .out_ready (out_ready)
    );

    tx_checker u_checker (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid0 (in_valid[0]),
        .in_valid1 (in_valid[1]),
        .in_ready0 (in_ready[0]),
        .in_ready1 (in_ready[1]),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_port  (out_port),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Output back-pressure
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rng       = 32'd78;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rng = xorshift32(rng);
            if ($time < stall_end) begin
                out_ready = 1'b0;                    // Forced stall lets a queue fill
            end else begin
                out_ready = (rng[1:0] != 2'b00);     // Low about one cycle in four
            end
        end
    end

    task automatic report_counts();
        errors = u_checker.data_errs + u_checker.frame_errs + u_checker.gap_errs
                 + u_checker.order_errs + u_checker.flow_errs + timeouts;
        $display("Errors: data %0d, framing %0d, gap %0d, order %0d, flow %0d, timeout %0d",
                 u_checker.data_errs, u_checker.frame_errs, u_checker.gap_errs,
                 u_checker.order_errs, u_checker.flow_errs, timeouts);
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        timeouts++;
        timed_out = 1'b1;
    endtask

    // Pushes one frame into a port, byte by byte, honoring in_ready
    task automatic send_frame(input int port, input int len, input int first);
        logic accepted;
        int   tries;
        for (int i = 0; i < len && !timed_out; i++) begin
            u_checker.expect_byte(port[0], data_w'(first + i), i == len - 1);
            in_data[port]  = data_w'(first + i);
            in_last[port]  = (i == len - 1);
            in_valid[port] = 1'b1;
            accepted = 1'b0;
            tries    = 0;
            while (!accepted && !timed_out) begin
                if (tries == byte_timeout) begin
                    note_timeout("input queue never became ready");
                end else begin
                    accepted = in_ready[port];           // Stable until the next edge
                    @(posedge clk);
                    #1;
                    tries++;
                end
            end
        end
        in_valid[port] = 1'b0;
        in_last[port]  = 1'b0;
    endtask

    task automatic wait_drained();
        int tries;
        tries = 0;
        while (!timed_out && !(u_checker.all_consumed() && !out_valid)) begin
            if (tries == drain_timeout) begin
                note_timeout("expected frames never left the DUT");
            end else begin
                @(posedge clk);
                #1;
                tries++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rstn      = 1'b0;
        in_data   = '0;
        in_last   = '0;
        in_valid  = '0;
        stall_end = 0;
        timeouts  = 0;
        errors    = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int r = 0; r < n_rows && !timed_out; r++) begin
            if (frame_table[r][3] != 0) begin
                wait_drained();                          // Both queues start empty
                u_checker.arm_order_check();
                fork
                    send_frame(frame_table[r][0], frame_table[r][1], frame_table[r][2]);
                    send_frame(frame_table[r + 1][0], frame_table[r + 1][1],
                               frame_table[r + 1][2]);
                join
                r++;
            end else begin
                if (frame_table[r][4] != 0) begin
                    stall_end = $time + frame_table[r][4] * clk_period;
                end
                send_frame(frame_table[r][0], frame_table[r][1], frame_table[r][2]);
            end
        end
        wait_drained();
        repeat (4) @(posedge clk);
        u_checker.check_queue_filled();
        report_counts();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- eth_tx_mux_top.f
rtl/eth_tx_pkg.sv
rtl/eth_arbiter.sv
rtl/frame_queue.sv
rtl/tx_stream_mux.sv
rtl/eth_tx_mux_top.sv
bench/tx_checker.sv
bench/tb_eth_tx_mux.sv
